// File: hdl/stage1Pkg.sv
package stage1Pkg;

	//////////////////////////////
	// Instruction format
	//////////////////////////////

	typedef logic [7:0] instrT;          // Opcode in [7:3], flags in [2:0]
	typedef logic [2:0] shiftCountT;
	typedef logic [34:0] ctrlWordT;

	typedef enum logic [4:0] {
		opAdd  = 5'b00000,
		opSub  = 5'b00001,
		opOr   = 5'b00011,
		opAnd  = 5'b00100,
		opShft = 5'b00101,
		opLoad = 5'b01010
	} opcodeT;

	// Addressing modes
	localparam logic [2:0] flDir = 3'b000;
	localparam logic [2:0] flInd = 3'b001;
	localparam logic [2:0] flImm = 3'b010;

	// Shift flavours, fill bit in the name
	localparam logic [2:0] flLs0 = 3'b000;
	localparam logic [2:0] flLs1 = 3'b001;
	localparam logic [2:0] flRs0 = 3'b010;
	localparam logic [2:0] flRs1 = 3'b011;

	//////////////////////////////
	// Controller states
	//////////////////////////////

	localparam int numStates = 26;

	typedef enum logic [4:0] {
		idle,
		dirFetch0,
		dirFetch1,
		operFetch,
		dispatch,
		indFetch0,
		indFetch1,
		indFetch2,
		indFetch3,
		indFetch4,
		immStart,
		execAddDir,
		execAddImm,
		execSubDir,
		execSubImm,
		execOrDir,
		execOrImm,
		execAndDir,
		execAndImm,
		loadDir,
		loadImm,
		shiftSelect,
		shiftLs0,
		shiftLs1,
		shiftRs0,
		shiftRs1
	} stateT;

	//////////////////////////////
	// Control words per state
	//////////////////////////////

	// Entry order follows stateT
	localparam ctrlWordT ctrlTable [numStates] = '{
		35'b10000000000010010100001110110000000, // idle
		35'b10000000000000011110001110110000000, // dirFetch0
		35'b10000000000010010101001110110000000, // dirFetch1
		35'b10000000000010010100001110110000000, // operFetch
		35'b10000000000010010100101110110000000, // dispatch
		35'b10000000000000011110001110110000000, // indFetch0
		35'b10000000000010010101001110110000000, // indFetch1
		35'b10000000000010010100001110110000000, // indFetch2
		35'b10000000000010010100101110110000000, // indFetch3
		35'b10000000000010010101001110110000000, // indFetch4
		35'b10000000000000011110001110110000000, // immStart
		35'b10100000000000010100001110110000000, // execAddDir
		35'b10100000000000010100001100110000000, // execAddImm
		35'b10100110000000010100001110110000000, // execSubDir
		35'b10100110000000010100001100110000000, // execSubImm
		35'b10101000000000010100001110110000000, // execOrDir
		35'b10101000000000010100001100110000000, // execOrImm
		35'b10110000000000010100001110110000000, // execAndDir
		35'b10110000000000010100001100110000000, // execAndImm
		35'b10100000000000010100000110110000000, // loadDir
		35'b10100000000000010100001010110000000, // loadImm
		35'b10000000000000010100001110110001000, // shiftSelect
		35'b10100000000000010100000010110010000, // shiftLs0
		35'b10100000000000010100000010110010100, // shiftLs1
		35'b10100000000000010100000010110011000, // shiftRs0
		35'b10100000000000010100000010110011010  // shiftRs1
	};

endpackage

// File: hdl/opDecoder.sv
`timescale 1ns/100ps

module opDecoder import stage1Pkg::*; (
	input instrT instr,
	output logic accept,
	output stateT entryState,
	output stateT dirExecState,
	output stateT immExecState,
	output stateT shiftExecState
);

	opcodeT opcode;
	logic [2:0] flag;
	logic isAlu;
	logic isLoad;

	assign opcode = opcodeT'(instr[7:3]);
	assign flag = instr[2:0];

	//////////////////////////////
	// Execute targets
	//////////////////////////////

	always_comb begin
		dirExecState = idle;
		immExecState = idle;
		isAlu = 1'b0;
		isLoad = 1'b0;
		case (opcode)
			opAdd: begin
				dirExecState = execAddDir;
				immExecState = execAddImm;
				isAlu = 1'b1;
			end
			opSub: begin
				dirExecState = execSubDir;
				immExecState = execSubImm;
				isAlu = 1'b1;
			end
			opOr: begin
				dirExecState = execOrDir;
				immExecState = execOrImm;
				isAlu = 1'b1;
			end
			opAnd: begin
				dirExecState = execAndDir;
				immExecState = execAndImm;
				isAlu = 1'b1;
			end
			opLoad: begin
				dirExecState = loadDir;
				immExecState = loadImm;
				isLoad = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		shiftExecState = idle;              // Idle marks a non-shift instruction
		if (opcode == opShft) begin
			case (flag)
				flLs0: shiftExecState = shiftLs0;
				flLs1: shiftExecState = shiftLs1;
				flRs0: shiftExecState = shiftRs0;
				flRs1: shiftExecState = shiftRs1;
				default: shiftExecState = idle;
			endcase
		end
	end

	//////////////////////////////
	// Entry path
	//////////////////////////////

	always_comb begin
		accept = 1'b0;
		entryState = idle;
		if (shiftExecState != idle) begin
			accept = 1'b1;
			entryState = dirFetch0;             // Shift shares the first fetch
		end else if (isAlu || isLoad) begin
			case (flag)
				flDir: begin
					accept = 1'b1;
					entryState = dirFetch0;
				end
				flInd: begin
					accept = isAlu;                 // No indirect LOAD
					entryState = isAlu ? indFetch0 : idle;
				end
				flImm: begin
					accept = 1'b1;
					entryState = immStart;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/stage1Sequencer.sv
`timescale 1ns/100ps

module stage1Sequencer import stage1Pkg::*; (
	input logic clk,
	input logic rstN,
	input logic stg0Valid,
	input logic accept,
	input stateT entryState,
	input stateT dirExecState,
	input stateT immExecState,
	input stateT shiftExecState,
	output stateT state
);

	stateT nextState;
	stateT dirTarget;
	stateT immTarget;
	stateT shiftTarget;
	logic take;

	// Handshake with stage 0
	assign take = (state == idle) && stg0Valid && accept;

	//////////////////////////////
	// State and branch targets
	//////////////////////////////

	// Targets are captured on the accepting edge so that stage 0 may
	// move on while the sequence runs
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			dirTarget <= idle;
			immTarget <= idle;
			shiftTarget <= idle;
		end else begin
			state <= nextState;
			if (take) begin
				dirTarget <= dirExecState;
				immTarget <= immExecState;
				shiftTarget <= shiftExecState;
			end
		end
	end

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		case (state)
			idle: nextState = take ? entryState : idle;
			dirFetch0: begin
				if (shiftTarget != idle)
					nextState = shiftSelect;      // SHFT skips the operand read
				else
					nextState = dirFetch1;
			end
			dirFetch1: nextState = operFetch;
			operFetch: nextState = dispatch;
			dispatch: nextState = dirTarget;   // Direct and indirect end here
			indFetch0: nextState = indFetch1;
			indFetch1: nextState = indFetch2;
			indFetch2: nextState = indFetch3;
			indFetch3: nextState = indFetch4;
			indFetch4: nextState = operFetch;  // Rejoin the direct chain
			immStart: nextState = immTarget;
			shiftSelect: nextState = shiftTarget;
			execAddDir,
			execAddImm,
			execSubDir,
			execSubImm,
			execOrDir,
			execOrImm,
			execAndDir,
			execAndImm,
			loadDir,
			loadImm,
			shiftLs0,
			shiftLs1,
			shiftRs0,
			shiftRs1: nextState = idle;
			default: nextState = idle;
		endcase
	end

endmodule

// File: hdl/controlStore.sv
`timescale 1ns/100ps

module controlStore import stage1Pkg::*; (
	input stateT state,
	input logic [7:0] irData,
	output ctrlWordT ctrl,
	output shiftCountT numShift,
	output logic stg1Ready
);

	logic inShift;

	//////////////////////////////
	// Control word lookup
	//////////////////////////////

	assign ctrl = ctrlTable[state];

	// Ready only while waiting for stage 0
	assign stg1Ready = (state == idle);

	//////////////////////////////
	// Shifter count
	//////////////////////////////

	always_comb begin
		case (state)
			shiftLs0,
			shiftLs1,
			shiftRs0,
			shiftRs1: inShift = 1'b1;
			default: inShift = 1'b0;
		endcase
	end

	// Amount comes from the IR data byte
	assign numShift = inShift ? shiftCountT'(irData[2:0]) : '0;

endmodule

// File: hdl/stage1Control.sv
`timescale 1ns/100ps

module stage1Control import stage1Pkg::*; (
	input logic clk,
	input logic rstN,
	input logic stg0Valid,
	input instrT instr,
	input logic [7:0] irData,
	output logic stg1Ready,
	output ctrlWordT ctrl,
	output shiftCountT numShift
);

	logic accept;
	stateT entryState;
	stateT dirExecState;
	stateT immExecState;
	stateT shiftExecState;
	stateT state;

	opDecoder opDecoder_inst (
		.instr          (instr),
		.accept         (accept),
		.entryState     (entryState),
		.dirExecState   (dirExecState),
		.immExecState   (immExecState),
		.shiftExecState (shiftExecState)
	);

	stage1Sequencer stage1Sequencer_inst (
		.clk            (clk),
		.rstN           (rstN),
		.stg0Valid      (stg0Valid),
		.accept         (accept),
		.entryState     (entryState),
		.dirExecState   (dirExecState),
		.immExecState   (immExecState),
		.shiftExecState (shiftExecState),
		.state          (state)
	);

	controlStore controlStore_inst (
		.state     (state),
		.irData    (irData),
		.ctrl      (ctrl),
		.numShift  (numShift),
		.stg1Ready (stg1Ready)
	);

endmodule

// File: tests/stage1ControlTb.sv
`timescale 1ns/100ps

module stage1ControlTb import stage1Pkg::*; ();

	localparam string inputPath = "tests/stage1Input.txt";
	localparam int extraShiftTests = 4;
	localparam ctrlWordT idleWord = 35'h4004A1D80;
	localparam ctrlWordT addImmWord = 35'h5000A1980;
	localparam ctrlWordT shiftWords [4] = '{
		35'h5000A0590,  // Left, fill 0
		35'h5000A0594,  // Left, fill 1
		35'h5000A0598,  // Right, fill 0
		35'h5000A059A   // Right, fill 1
	};

	logic clk;
	logic rstN;
	logic stg0Valid;
	instrT instr;
	logic [7:0] irData;
	logic stg1Ready;
	ctrlWordT ctrl;
	shiftCountT numShift;

	// Test vectors from the data file
	logic [7:0] vecInstr [$];
	logic [7:0] vecIrData [$];
	int vecBusy [$];
	ctrlWordT vecCtrl [$];
	int vecShift [$];

	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	stage1Control stage1Control_inst (
		.clk       (clk),
		.rstN      (rstN),
		.stg0Valid (stg0Valid),
		.instr     (instr),
		.irData    (irData),
		.stg1Ready (stg1Ready),
		.ctrl      (ctrl),
		.numShift  (numShift)
	);

	//////////////////////////////
	// Clock and watchdog
	//////////////////////////////

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Something failed");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		logic [7:0] a;
		logic [7:0] b;
		int c;
		ctrlWordT d;
		int e;
		fd = $fopen(inputPath, "r");
		if (fd == 0) begin
			$display("Could not open %s, no file-driven tests were run", inputPath);
			failCount++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %d %h %d", a, b, c, d, e);
					if (n == 5) begin
						vecInstr.push_back(a);
						vecIrData.push_back(b);
						vecBusy.push_back(c);
						vecCtrl.push_back(d);
						vecShift.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Called 10 ns after a rising edge
	task automatic runTest(input int idx, input logic [7:0] tInstr, input logic [7:0] tIr,
			input int expBusy, input ctrlWordT expCtrl, input int expShift);
		int busy;
		int waited;
		ctrlWordT lastCtrl;
		shiftCountT lastShift;
		bit ok;
		busy = 0;
		waited = 0;
		lastCtrl = '0;
		lastShift = '0;
		ok = 1'b1;
		while (stg1Ready !== 1'b1) begin
			@(posedge clk);
			#10;
		end
		stg0Valid = 1'b1;
		instr = tInstr;
		irData = tIr;
		while (waited < 2 && busy == 0) begin
			@(posedge clk);
			#10;
			waited++;
			if (stg1Ready === 1'b0) begin
				busy = 1;
				lastCtrl = ctrl;
				lastShift = numShift;
			end
		end
		while (busy > 0 && stg1Ready === 1'b0) begin
			stg0Valid = $urandom % 2;                 // Stage 0 noise while busy
			instr = $urandom;
			@(posedge clk);
			#10;
			if (stg1Ready === 1'b0) begin
				busy++;
				lastCtrl = ctrl;
				lastShift = numShift;
			end
		end
		stg0Valid = 1'b0;
		assert (busy == expBusy) else begin
			$display("** Error at %0t: instr %h busy %0d cycles, expected %0d",
				$time, tInstr, busy, expBusy);
			ok = 1'b0;
		end
		if (expBusy > 0) begin
			assert (lastCtrl === expCtrl) else begin
				$display("** Error at %0t: instr %h last ctrl %h, expected %h",
					$time, tInstr, lastCtrl, expCtrl);
				ok = 1'b0;
			end
			assert (lastShift === shiftCountT'(expShift)) else begin
				$display("** Error at %0t: instr %h numShift %0d, expected %0d",
					$time, tInstr, lastShift, expShift);
				ok = 1'b0;
			end
		end
		if (ok)
			passCount++;
		else
			failCount++;
		$display("Test %0d instr %h irData %h busy %0d: %s", idx, tInstr, tIr, busy,
			ok ? "pass" : "FAIL");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		bit ok;
		logic [7:0] randIr;
		int k;
		void'($urandom(58521));
		rstN = 1'b0;
		stg0Valid = 1'b0;
		instr = '0;
		irData = 8'hFF;                            // Count must still read 0 in idle
		loadVectors();
		cycleLimit = 12 * (vecInstr.size() + 2 * extraShiftTests + 1) + 10;

		repeat (5) @(posedge clk);
		#10;
		rstN = 1'b1;

		// Idle outputs before any stimulus
		ok = 1'b1;
		assert (stg1Ready === 1'b1) else begin
			$display("** Error at %0t: stg1Ready %b after reset, expected 1", $time, stg1Ready);
			ok = 1'b0;
		end
		assert (numShift === 3'd0) else begin
			$display("** Error at %0t: numShift %0d after reset, expected 0", $time, numShift);
			ok = 1'b0;
		end
		assert (ctrl === idleWord) else begin
			$display("** Error at %0t: ctrl %h after reset, expected %h", $time, ctrl, idleWord);
			ok = 1'b0;
		end
		if (ok)
			passCount++;
		else
			failCount++;
		$display("Test 0 reset state: %s", ok ? "pass" : "FAIL");

		for (k = 0; k < vecInstr.size(); k++)
			runTest(k + 1, vecInstr[k], vecIrData[k], vecBusy[k], vecCtrl[k], vecShift[k]);

		// Random IR data for each shift and for one immediate ADD
		for (k = 0; k < extraShiftTests; k++) begin
			randIr = $urandom;
			runTest(vecInstr.size() + 2 * k + 1, 8'h28 + k[7:0], randIr, 3, shiftWords[k],
				randIr[2:0]);
			runTest(vecInstr.size() + 2 * k + 2, 8'h02, randIr, 2, addImmWord, 0);
		end

		$display("Tests run %0d, passed %0d, failed %0d", passCount + failCount, passCount,
			failCount);
		if (failCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: tests/stage1Input.txt
# instr(hex) irData(hex) busyCycles(dec, 0 = not accepted) lastCtrl(hex) lastNumShift(dec)
# ALU direct/indirect/immediate, LOAD, SHFT, then bytes that must be refused
00 00 5 5000A1D80 0
01 00 8 5000A1D80 0
02 00 2 5000A1980 0
08 00 5 5300A1D80 0
09 00 8 5300A1D80 0
0A 00 2 5300A1980 0
18 00 5 5400A1D80 0
19 00 8 5400A1D80 0
1A 00 2 5400A1980 0
20 00 5 5800A1D80 0
21 00 8 5800A1D80 0
22 00 2 5800A1980 0
50 00 5 5000A0D80 0
52 00 2 5000A1580 0
28 05 3 5000A0590 5
29 03 3 5000A0594 3
2A 7E 3 5000A0598 6
2B F1 3 5000A059A 1
10 00 0 000000000 0
03 00 0 000000000 0
51 00 0 000000000 0
2C 07 0 000000000 0

// File: src.f
hdl/stage1Pkg.sv
hdl/opDecoder.sv
hdl/stage1Sequencer.sv
hdl/controlStore.sv
hdl/stage1Control.sv
tests/stage1ControlTb.sv

// File: Bender.yml
package:
  name: stage1_control

dependencies: {}

sources:
  - files:
      - hdl/stage1Pkg.sv
      - hdl/opDecoder.sv
      - hdl/stage1Sequencer.sv
      - hdl/controlStore.sv
      - hdl/stage1Control.sv
  - target: test
    files:
      - tests/stage1ControlTb.sv
